// File: src.f
verilog/ooo_pkg.sv
verilog/issue_if.sv
verilog/completion_if.sv
verilog/phys_regfile.sv
verilog/dispatcher.sv
verilog/reservation_station.sv
verilog/wb_arbiter.sv
verilog/ooo_issue_top.sv
tests/ooo_issue_assert.sv
tests/ooo_issue_tb.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  - verilog/ooo_pkg.sv
  - verilog/issue_if.sv
  - verilog/completion_if.sv
  - verilog/phys_regfile.sv
  - verilog/dispatcher.sv
  - verilog/reservation_station.sv
  - verilog/wb_arbiter.sv
  - verilog/ooo_issue_top.sv
  - target: test
    files:
      - tests/ooo_issue_assert.sv
      - tests/ooo_issue_tb.sv

// File: tests/ooo_issue_tb.sv
module ooo_issue_tb;
    import ooo_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    alu_op_t               in_op;
    phys_tag_t             in_src1;
    phys_tag_t             in_src2;
    logic                  in_src2_imm;
    logic [data_width-1:0] in_imm;
    phys_tag_t             in_dest;
    logic                  in_ready;
    logic                  out_valid;
    phys_tag_t             out_tag;
    logic [data_width-1:0] out_data;

    // stimulus table, one op per entry
    alu_op_t               tbl_op[$];
    phys_tag_t             tbl_src1[$];
    phys_tag_t             tbl_src2[$];
    logic                  tbl_imm_sel[$];
    logic [data_width-1:0] tbl_imm[$];
    phys_tag_t             tbl_dest[$];
    int                    test_start [8];   // first entry of each test

    logic [data_width-1:0] model_rf [n_phys];
    logic [data_width-1:0] expect_val [n_phys];
    logic                  expect_on [n_phys];
    logic                  got [n_phys];
    int                    arrival [n_phys];
    int                    arrive_cnt;
    int                    errors;
    int                    tests_passed;
    int                    tests_failed;
    logic                  stall_seen;
    logic                  table_ready;
    int unsigned           watchdog_cycles;

    ooo_issue_top UUT (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_op(in_op),
        .in_src1(in_src1),
        .in_src2(in_src2),
        .in_src2_imm(in_src2_imm),
        .in_imm(in_imm),
        .in_dest(in_dest),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_tag(out_tag),
        .out_data(out_data)
    );

    always #4 clk = ~clk;

    function automatic logic [data_width-1:0] model_alu(alu_op_t op,
            logic [data_width-1:0] a, logic [data_width-1:0] b);
        logic [2*data_width-1:0] ext;
        logic [4:0]              sh;
        sh  = b[4:0];
        ext = {{data_width{a[31]}}, a} >> sh;   // sign-filled upper half
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << sh;
            op_srl:  return a >> sh;
            op_sra:  return ext[data_width-1:0];
            op_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            op_sltu: return {31'b0, a < b};
            op_imm:  return b;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(string name, logic [data_width-1:0] actual,
            logic [data_width-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_entry(alu_op_t op, phys_tag_t s1, phys_tag_t s2, logic imm_sel,
            logic [data_width-1:0] imm, phys_tag_t dest);
        tbl_op.push_back(op);
        tbl_src1.push_back(s1);
        tbl_src2.push_back(s2);
        tbl_imm_sel.push_back(imm_sel);
        tbl_imm.push_back(imm);
        tbl_dest.push_back(dest);
    endtask

    task automatic build_table();
        phys_tag_t prev;
        test_start[2] = tbl_op.size();
        for (int k = 0; k < 8; k++)
            add_entry(op_imm, '0, '0, 1'b1, $urandom, phys_tag_t'(1 + k));
        test_start[3] = tbl_op.size();
        for (int k = 0; k < 10; k++)   // add through sltu
            add_entry(alu_op_t'(k), phys_tag_t'(1 + $urandom % 8),
                      phys_tag_t'(1 + $urandom % 8), 1'b0, '0, phys_tag_t'(10 + k));
        test_start[4] = tbl_op.size();
        prev = 1;
        for (int k = 0; k < 8; k++) begin
            if (k % 2 == 0)
                add_entry(alu_op_t'((k * 3) % 10), prev, '0, 1'b1, $urandom,
                          phys_tag_t'(20 + k));
            else
                add_entry(alu_op_t'((k * 3) % 10), prev, phys_tag_t'(2 + k % 6), 1'b0, '0,
                          phys_tag_t'(20 + k));
            prev = phys_tag_t'(20 + k);
        end
        test_start[5] = tbl_op.size();
        // slow producer chain, dest tags reused from test 3
        add_entry(op_imm, '0, '0, 1'b1, $urandom, 10);
        add_entry(op_add, 10, 10, 1'b0, '0, 11);
        add_entry(op_xor, 11, 3, 1'b0, '0, 12);
        for (int k = 0; k < 6; k++)
            add_entry(alu_op_t'(k), 12, (k % 2 == 1) ? phys_tag_t'(12) : phys_tag_t'(5),
                      1'b0, '0, phys_tag_t'(13 + k));
        test_start[6] = tbl_op.size();
        add_entry(op_imm, '0, '0, 1'b1, $urandom, 40);
        add_entry(op_add, 40, 1, 1'b0, '0, 41);
        add_entry(op_sub, 41, 2, 1'b0, '0, 42);           // stalled dependent
        add_entry(op_or, 3, 4, 1'b0, '0, 43);             // independent
        test_start[7] = tbl_op.size();
    endtask

    function automatic logic all_arrived();
        for (int n = 0; n < n_phys; n++)
            if (expect_on[n] && !got[n])
                return 1'b0;
        return 1'b1;
    endfunction

    task automatic finish_test(int t, string name, int err0);
        if (errors == err0) begin
            tests_passed++;
            $display("test %0d %s: ok", t, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", t, name, errors - err0);
        end
    endtask

    task automatic run_test(int t, string name);
        int                    err0;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        err0       = errors;
        stall_seen = 1'b0;
        for (int n = 0; n < n_phys; n++) begin
            expect_on[n] = 1'b0;
            got[n]       = 1'b0;
        end
        // model runs in table order, each tag is written once per test
        for (int i = test_start[t]; i < test_start[t+1]; i++) begin
            a = model_rf[tbl_src1[i]];
            b = tbl_imm_sel[i] ? tbl_imm[i] : model_rf[tbl_src2[i]];
            model_rf[tbl_dest[i]]   = model_alu(tbl_op[i], a, b);
            expect_val[tbl_dest[i]] = model_rf[tbl_dest[i]];
            expect_on[tbl_dest[i]]  = 1'b1;
        end
        for (int i = test_start[t]; i < test_start[t+1]; i++) begin
            in_valid    = 1'b1;
            in_op       = tbl_op[i];
            in_src1     = tbl_src1[i];
            in_src2     = tbl_src2[i];
            in_src2_imm = tbl_imm_sel[i];
            in_imm      = tbl_imm[i];
            in_dest     = tbl_dest[i];
            while (!in_ready) begin
                stall_seen = 1'b1;
                @(negedge clk);
            end
            @(negedge clk);     // accepted on the rising edge in between
        end
        in_valid = 1'b0;
        while (!all_arrived())
            @(negedge clk);
        repeat (2) @(negedge clk);
        if (t == 5 && !stall_seen) begin
            $display("in_ready never dropped while ops were waiting on tag 12");
            errors++;
        end
        if (t == 6 && arrival[43] > arrival[42]) begin
            $display("tag 43 did not complete ahead of tag 42");
            errors++;
        end
        finish_test(t, name, err0);
    endtask

    // result monitor
    always @(negedge clk) begin
        if (!reset && out_valid === 1'b1) begin
            if (!expect_on[out_tag]) begin
                $display("unexpected result for tag %0d", out_tag);
                errors++;
            end else if (got[out_tag]) begin
                $display("duplicate result for tag %0d", out_tag);
                errors++;
            end else begin
                check_value($sformatf("out_data tag %0d", out_tag), out_data,
                            expect_val[out_tag]);
                got[out_tag]     = 1'b1;
                arrival[out_tag] = arrive_cnt;
                arrive_cnt++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, results still missing", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int err0;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_op       = op_add;
        in_src1     = '0;
        in_src2     = '0;
        in_src2_imm = 1'b0;
        in_imm      = '0;
        in_dest     = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        arrive_cnt   = 0;
        stall_seen   = 1'b0;
        table_ready  = 1'b0;
        for (int n = 0; n < n_phys; n++) begin
            model_rf[n]  = '0;
            expect_on[n] = 1'b0;
            got[n]       = 1'b0;
            arrival[n]   = 0;
        end
        void'($urandom(32'hbf17_188e));
        build_table();
        watchdog_cycles = tbl_op.size() * 20 + 200;
        table_ready     = 1'b1;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        err0 = errors;
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        finish_test(1, "reset state", err0);

        run_test(2, "immediate loads");
        run_test(3, "alu ops");
        run_test(4, "dependent chain");
        run_test(5, "input stall");
        run_test(6, "out of order completion");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0 && UUT.u_assert.fail_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: tests/ooo_issue_assert.sv
module ooo_issue_assert (
    input logic               clk,
    input logic               reset,
    input logic               in_valid,
    input logic               in_ready,
    input ooo_pkg::phys_tag_t in_dest,
    input logic               out_valid,
    input ooo_pkg::phys_tag_t out_tag
);
    import ooo_pkg::*;

    logic [n_phys-1:0] in_flight;   // accepted, not yet broadcast
    logic              accept;
    int unsigned       fail_count = 0;

    assign accept = in_valid && in_ready && (in_dest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            if (out_valid)
                in_flight[out_tag] <= 1'b0;
            if (accept)
                in_flight[in_dest] <= 1'b1;
        end
    end

    a_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_tag != '0)
        else begin
            $error("broadcast with tag 0");
            fail_count++;
        end

    // covers the reset cycles and the first cycle after reset
    a_quiet_reset: assert property (@(posedge clk)
        $past(reset) || $past(reset, 2) |-> !out_valid)
        else begin
            $error("out_valid high during or right after reset");
            fail_count++;
        end

    a_no_reaccept: assert property (@(posedge clk) disable iff (reset)
        accept |-> !in_flight[in_dest] || (out_valid && out_tag == in_dest))
        else begin
            $error("dest tag accepted again before its broadcast");
            fail_count++;
        end

    a_single_bcast: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> in_flight[out_tag])
        else begin
            $error("broadcast of a tag that is not in flight");
            fail_count++;
        end

endmodule

bind ooo_issue_top ooo_issue_assert u_assert (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_dest(in_dest),
    .out_valid(out_valid),
    .out_tag(out_tag)
);

// File: verilog/ooo_issue_top.sv
module ooo_issue_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  ooo_pkg::alu_op_t               in_op,
    input  ooo_pkg::phys_tag_t             in_src1,
    input  ooo_pkg::phys_tag_t             in_src2,
    input  logic                           in_src2_imm,
    input  logic [ooo_pkg::data_width-1:0] in_imm,
    input  ooo_pkg::phys_tag_t             in_dest,
    output logic                           in_ready,
    output logic                           out_valid,
    output ooo_pkg::phys_tag_t             out_tag,
    output logic [ooo_pkg::data_width-1:0] out_data
);
    import ooo_pkg::*;

    bcast_t                bcast;
    phys_tag_t             rd_tag1, rd_tag2;
    logic [data_width-1:0] rd_data1, rd_data2;
    logic                  rd_ready1, rd_ready2;
    phys_tag_t             alloc_tag;
    logic                  alloc;

    issue_if      iss [n_rs] ();
    completion_if cpl [n_rs] ();

    phys_regfile u_regfile (
        .clk(clk),
        .reset(reset),
        .rd_tag1(rd_tag1),
        .rd_tag2(rd_tag2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .rd_ready1(rd_ready1),
        .rd_ready2(rd_ready2),
        .wr(bcast),
        .alloc_tag(alloc_tag),
        .alloc(alloc)
    );

    dispatcher u_dispatcher (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_src2_imm(in_src2_imm),
        .in_op(in_op),
        .in_src1(in_src1),
        .in_src2(in_src2),
        .in_dest(in_dest),
        .in_imm(in_imm),
        .bcast(bcast),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .rd_ready1(rd_ready1),
        .rd_ready2(rd_ready2),
        .in_ready(in_ready),
        .rd_tag1(rd_tag1),
        .rd_tag2(rd_tag2),
        .alloc_tag(alloc_tag),
        .alloc(alloc),
        .iss(iss)
    );

    for (genvar i = 0; i < n_rs; i++) begin : g_rs
        reservation_station u_rs (
            .clk(clk),
            .reset(reset),
            .iss(iss[i]),
            .bcast(bcast),
            .cpl(cpl[i])
        );
    end

    wb_arbiter u_arbiter (
        .clk(clk),
        .reset(reset),
        .cpl(cpl),
        .bcast(bcast)
    );

    assign out_valid = bcast.valid;
    assign out_tag   = bcast.tag;
    assign out_data  = bcast.data;

endmodule

// File: verilog/wb_arbiter.sv
module wb_arbiter (
    input  logic             clk,
    input  logic             reset,
    completion_if.arbiter    cpl [ooo_pkg::n_rs],
    output ooo_pkg::bcast_t  bcast
);
    import ooo_pkg::*;

    logic [n_rs-1:0]         req;
    logic [n_rs-1:0]         gnt;
    phys_tag_t               req_tag [n_rs];
    logic [data_width-1:0]   req_data [n_rs];
    logic [rs_idx_width-1:0] last_q;    // previous winner
    logic [rs_idx_width-1:0] win;
    logic                    any;

    for (genvar i = 0; i < n_rs; i++) begin : g_port
        assign req[i]       = cpl[i].req;
        assign req_tag[i]   = cpl[i].tag;
        assign req_data[i]  = cpl[i].data;
        assign cpl[i].grant = gnt[i];
    end

    // search starts one past the last winner
    always_comb begin
        int unsigned idx;
        gnt = '0;
        win = last_q;
        any = 1'b0;
        for (int k = 1; k <= n_rs; k++) begin
            idx = (int'(last_q) + k) % n_rs;
            if (!any && req[idx]) begin
                gnt[idx] = 1'b1;
                win      = rs_idx_width'(idx);
                any      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bcast.valid <= 1'b0;
            last_q      <= rs_idx_width'(n_rs - 1);    // station 0 goes first
        end else begin
            bcast.valid <= any;
            if (any)
                last_q <= win;
        end
        if (any) begin
            bcast.tag  <= req_tag[win];
            bcast.data <= req_data[win];
        end
    end

endmodule

// File: verilog/reservation_station.sv
module reservation_station (
    input  logic            clk,
    input  logic            reset,
    issue_if.station        iss,
    input  ooo_pkg::bcast_t bcast,
    completion_if.station   cpl
);
    import ooo_pkg::*;

    logic                  busy;
    logic                  done;    // result held, waiting for grant
    alu_op_t               op_q;
    phys_tag_t             dest_q;
    phys_tag_t             tag1_q, tag2_q;
    logic [data_width-1:0] val1_q, val2_q;
    logic                  rdy1_q, rdy2_q;
    logic [data_width-1:0] result_q;
    logic                  take;
    logic                  wake1, wake2;
    logic                  fire;

    assign take = iss.valid && iss.ready;

    // snoop starts the cycle after entry, the dispatcher covers the entry cycle
    assign wake1 = busy && !rdy1_q && bcast.valid && (bcast.tag == tag1_q);
    assign wake2 = busy && !rdy2_q && bcast.valid && (bcast.tag == tag2_q);
    assign fire  = busy && !done && rdy1_q && rdy2_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (done && cpl.grant) begin
            busy <= 1'b0;   // free on grant
            done <= 1'b0;
        end else if (fire) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q   <= iss.op;
            dest_q <= iss.dest;
            tag1_q <= iss.src1_tag;
            tag2_q <= iss.src2_tag;
            val1_q <= iss.src1_val;
            val2_q <= iss.src2_val;
            rdy1_q <= iss.src1_rdy;
            rdy2_q <= iss.src2_rdy;
        end else begin
            if (wake1) begin
                val1_q <= bcast.data;
                rdy1_q <= 1'b1;
            end
            if (wake2) begin
                val2_q <= bcast.data;
                rdy2_q <= 1'b1;
            end
        end
        if (fire)
            result_q <= alu_eval(op_q, val1_q, val2_q);
    end

    assign iss.ready = !busy;
    assign cpl.req   = done;
    assign cpl.tag   = dest_q;
    assign cpl.data  = result_q;

endmodule

// File: verilog/dispatcher.sv
module dispatcher (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic                           in_src2_imm,
    input  ooo_pkg::alu_op_t               in_op,
    input  ooo_pkg::phys_tag_t             in_src1,
    input  ooo_pkg::phys_tag_t             in_src2,
    input  ooo_pkg::phys_tag_t             in_dest,
    input  logic [ooo_pkg::data_width-1:0] in_imm,
    input  ooo_pkg::bcast_t                bcast,
    input  logic [ooo_pkg::data_width-1:0] rd_data1,
    input  logic [ooo_pkg::data_width-1:0] rd_data2,
    input  logic                           rd_ready1,
    input  logic                           rd_ready2,
    output logic                           in_ready,
    output ooo_pkg::phys_tag_t             rd_tag1,
    output ooo_pkg::phys_tag_t             rd_tag2,
    output ooo_pkg::phys_tag_t             alloc_tag,
    output logic                           alloc,
    issue_if.dispatch                      iss [ooo_pkg::n_rs]
);
    import ooo_pkg::*;

    logic [n_rs-1:0]       free;
    logic [n_rs-1:0]       pick;
    logic                  accept;
    logic                  hit1, hit2;
    logic                  stale1, stale2;
    logic [data_width-1:0] src1_val, src2_val;
    logic                  src1_rdy, src2_rdy;

    assign rd_tag1 = in_src1;
    assign rd_tag2 = in_src2;

    for (genvar i = 0; i < n_rs; i++) begin : g_free
        assign free[i] = iss[i].ready;
    end

    assign pick     = free & (~free + 1'b1);   // lowest free station
    assign in_ready = |free;
    assign accept   = in_valid && in_ready;

    // the valid clear reaches the regfile one cycle late,
    // so a tag accepted last cycle is forced not ready here
    assign stale1 = alloc && (alloc_tag == in_src1);
    assign stale2 = alloc && (alloc_tag == in_src2);
    assign hit1   = bcast.valid && (bcast.tag == in_src1);
    assign hit2   = bcast.valid && (bcast.tag == in_src2);

    assign src1_val = hit1 ? bcast.data : rd_data1;
    assign src1_rdy = !stale1 && (hit1 || rd_ready1);
    assign src2_val = in_src2_imm ? in_imm : (hit2 ? bcast.data : rd_data2);
    assign src2_rdy = in_src2_imm || (!stale2 && (hit2 || rd_ready2));

    always_ff @(posedge clk) begin
        if (reset)
            alloc <= 1'b0;
        else
            alloc <= accept && (in_dest != '0);
    end

    always_ff @(posedge clk) begin
        if (accept)
            alloc_tag <= in_dest;
    end

    for (genvar i = 0; i < n_rs; i++) begin : g_issue
        assign iss[i].valid    = accept && pick[i];
        assign iss[i].op       = in_op;
        assign iss[i].dest     = in_dest;
        assign iss[i].src1_val = src1_val;
        assign iss[i].src1_rdy = src1_rdy;
        assign iss[i].src1_tag = in_src1;
        assign iss[i].src2_val = src2_val;
        assign iss[i].src2_rdy = src2_rdy;
        assign iss[i].src2_tag = in_src2;
    end

endmodule

// File: verilog/phys_regfile.sv
module phys_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  ooo_pkg::phys_tag_t            rd_tag1,
    input  ooo_pkg::phys_tag_t            rd_tag2,
    output logic [ooo_pkg::data_width-1:0] rd_data1,
    output logic [ooo_pkg::data_width-1:0] rd_data2,
    output logic                          rd_ready1,
    output logic                          rd_ready2,
    input  ooo_pkg::bcast_t               wr,
    input  ooo_pkg::phys_tag_t            alloc_tag,
    input  logic                          alloc
);
    import ooo_pkg::*;

    logic [data_width-1:0] regs [n_phys];
    logic [n_phys-1:0]     valid_q;
    logic                  wr_en;
    logic                  alloc_en;

    // tag 0 is hardwired, never written
    assign wr_en    = wr.valid && (wr.tag != '0);
    assign alloc_en = alloc && (alloc_tag != '0);

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wr.tag] <= wr.data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= n_phys'(1);
        end else begin
            if (wr_en)
                valid_q[wr.tag] <= 1'b1;
            if (alloc_en)
                valid_q[alloc_tag] <= 1'b0;     // new producer wins
        end
    end

    assign rd_data1  = (rd_tag1 == '0) ? '0 : regs[rd_tag1];
    assign rd_data2  = (rd_tag2 == '0) ? '0 : regs[rd_tag2];
    assign rd_ready1 = valid_q[rd_tag1];
    assign rd_ready2 = valid_q[rd_tag2];

endmodule

// File: verilog/completion_if.sv
interface completion_if;
    import ooo_pkg::*;

    logic                  req;
    logic                  grant;
    phys_tag_t             tag;
    logic [data_width-1:0] data;

    // req, tag and data stay stable until grant
    modport station (
        output req, tag, data,
        input  grant
    );

    modport arbiter (
        input  req, tag, data,
        output grant
    );

endinterface

// File: verilog/issue_if.sv
interface issue_if;
    import ooo_pkg::*;

    logic                  valid;
    logic                  ready;       // station is free
    alu_op_t               op;
    phys_tag_t             dest;
    logic [data_width-1:0] src1_val;
    logic                  src1_rdy;
    phys_tag_t             src1_tag;
    logic [data_width-1:0] src2_val;
    logic                  src2_rdy;
    phys_tag_t             src2_tag;

    modport dispatch (
        output valid, op, dest, src1_val, src1_rdy, src1_tag, src2_val, src2_rdy, src2_tag,
        input  ready
    );

    modport station (
        input  valid, op, dest, src1_val, src1_rdy, src1_tag, src2_val, src2_rdy, src2_tag,
        output ready
    );

endinterface

// File: verilog/ooo_pkg.sv
package ooo_pkg;

    localparam int data_width   = 32;
    localparam int n_phys       = 64;
    localparam int tag_width    = $clog2(n_phys);
    localparam int n_rs         = 4;
    localparam int rs_idx_width = $clog2(n_rs);

    typedef logic [tag_width-1:0] phys_tag_t;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_imm  = 4'd10     // passes operand b through
    } alu_op_t;

    // result bus, 1 + tag_width + data_width bits
    typedef struct packed {
        logic                  valid;
        phys_tag_t             tag;
        logic [data_width-1:0] data;
    } bcast_t;

    function automatic logic [data_width-1:0] alu_eval(
        alu_op_t               op,
        logic [data_width-1:0] a,
        logic [data_width-1:0] b
    );
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << shamt;
            op_srl:  return a >> shamt;
            op_sra:  return $signed(a) >>> shamt;
            op_slt:  return {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: return {{(data_width-1){1'b0}}, a < b};
            op_imm:  return b;
            default: return '0;
        endcase
    endfunction

endpackage
